// ==== simd_driver_params.svh ====
//======================================
// SIMD driver parameters
// Widths, dimension count and limits
//======================================
`ifndef SIMD_DRIVER_PARAMS_SVH
`define SIMD_DRIVER_PARAMS_SVH

// Offset space
`define SD_VDIM 2
`define SD_WBW 8

// Instruction identifiers, width holds SD_N_INST itself as an end bound
`define SD_N_INST 16
`define SD_INST_BW 5

// Warps and flow limit
`define SD_MAX_WARP 4
`define SD_WID_BW 2
`define SD_N_PENDING 6

// Level runs from 0 to SD_VDIM
`define SD_LVL_BW 2

`endif

// ==== simd_driver_pkg.sv ====
//======================================
// SIMD driver types
// Job, point, range and instruction records
//======================================
`include "simd_driver_params.svh"

package simd_driver_pkg;

	// One offset per dimension, dimension 0 is innermost
	typedef logic [`SD_VDIM-1:0][`SD_WBW-1:0] ofs_t;
	// One identifier per level
	typedef logic [`SD_VDIM:0][`SD_INST_BW-1:0] id_tbl_t;

	// Job as held on the input port
	typedef struct packed {
		ofs_t    aofs_beg;
		// End is exclusive
		ofs_t    aofs_end;
		ofs_t    bofs;
		id_tbl_t id_begs;
		id_tbl_t id_ends;
	} job_t;

	// One A point with its boundary levels
	typedef struct packed {
		ofs_t                  aofs;
		logic [`SD_LVL_BW-1:0] lvl_beg;
		logic [`SD_LVL_BW-1:0] lvl_end;
		logic                  islast;
	} point_t;

	// Non-empty identifier range of one point
	typedef struct packed {
		ofs_t                   aofs;
		logic [`SD_INST_BW-1:0] id_beg;
		logic [`SD_INST_BW-1:0] id_end;
		logic                   islast;
	} range_t;

	// Issued instruction record
	typedef struct packed {
		logic [`SD_INST_BW-1:0] pc;
		logic [`SD_WID_BW-1:0]  warpid;
		ofs_t                   aofs;
		ofs_t                   bofs;
	} inst_t;

	// Job sequencer states
	typedef enum logic [1:0] {
		IDLE,
		WALK,
		DRAIN,
		ACK
	} ctrl_state_e;

endpackage

// ==== offset_stepper.sv ====
//======================================
// Offset stepper
// Walks the A range row-major, tags levels
//======================================
`include "simd_driver_params.svh"

module offset_stepper import simd_driver_pkg::*; (
	input  logic   i_clk,
	input  logic   i_arst_n,
	input  logic   i_start,
	input  job_t   i_job,
	output logic   o_pt_valid,
	input  logic   i_pt_ready,
	output point_t o_pt
);

//======================================
// Internal
//======================================
logic [`SD_VDIM-1:0][`SD_WBW-1:0] cnt;
logic [`SD_VDIM-1:0][`SD_WBW-1:0] cnt_nxt;
logic [`SD_VDIM-1:0]              at_beg;
logic [`SD_VDIM-1:0]              at_last;
logic [`SD_LVL_BW-1:0]            lvl_beg;
logic [`SD_LVL_BW-1:0]            lvl_end;
logic                             run_beg;
logic                             run_end;
logic                             carry;
logic                             pt_fire;

//======================================
// Combinational
//======================================
// Per-dimension boundary flags
always_comb begin
	for (int d = 0; d < `SD_VDIM; d++) begin
		at_beg[d] = cnt[d] == i_job.aofs_beg[d];
		at_last[d] = cnt[d] == i_job.aofs_end[d] - 1'b1;
	end
end

// Count consecutive boundary dims from the innermost one
always_comb begin
	lvl_beg = '0;
	lvl_end = '0;
	run_beg = 1'b1;
	run_end = 1'b1;
	for (int d = 0; d < `SD_VDIM; d++) begin
		run_beg = run_beg & at_beg[d];
		run_end = run_end & at_last[d];
		if (run_beg) begin
			lvl_beg = lvl_beg + 1'b1;
		end
		if (run_end) begin
			lvl_end = lvl_end + 1'b1;
		end
	end
end

// Row-major increment, a dim wraps to its start when it rolls over
always_comb begin
	cnt_nxt = cnt;
	carry = 1'b1;
	for (int d = 0; d < `SD_VDIM; d++) begin
		if (carry) begin
			cnt_nxt[d] = at_last[d] ? i_job.aofs_beg[d] : cnt[d] + 1'b1;
		end
		carry = carry & at_last[d];
	end
end

assign pt_fire = o_pt_valid && i_pt_ready;

// Last point is the one where every dim sits at end minus one
assign o_pt.aofs = cnt;
assign o_pt.lvl_beg = lvl_beg;
assign o_pt.lvl_end = lvl_end;
assign o_pt.islast = &at_last;

//======================================
// Sequential
//======================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		o_pt_valid <= 1'b0;
	end else if (i_start) begin
		o_pt_valid <= 1'b1;
	end else if (pt_fire && o_pt.islast) begin
		o_pt_valid <= 1'b0;
	end
end

// Counters load on start and move only when a point is taken
always_ff @(posedge i_clk) begin
	if (i_start) begin
		cnt <= i_job.aofs_beg;
	end else if (pt_fire) begin
		cnt <= cnt_nxt;
	end
end

endmodule

// ==== inst_range_select.sv ====
//======================================
// Identifier range select
// Level lookup stage, drops empty ranges
//======================================
`include "simd_driver_params.svh"

module inst_range_select import simd_driver_pkg::*; (
	input  logic   i_clk,
	input  logic   i_arst_n,
	input  logic   i_pt_valid,
	output logic   o_pt_ready,
	input  point_t i_pt,
	input  job_t   i_job,
	output logic   o_rng_valid,
	input  logic   i_rng_ready,
	output range_t o_rng,
	output logic   o_skip_last
);

//======================================
// Internal
//======================================
logic                   pt_acc;
logic                   empty;
logic [`SD_INST_BW-1:0] id_beg;
logic [`SD_INST_BW-1:0] id_end;

//======================================
// Combinational
//======================================
// Take a new point when the output slot is free or leaving
assign o_pt_ready = !o_rng_valid || i_rng_ready;
assign pt_acc = i_pt_valid && o_pt_ready;

// Prologue and epilogue pick by level
assign id_beg = i_job.id_begs[i_pt.lvl_beg];
assign id_end = i_job.id_ends[i_pt.lvl_end];
// Inverted bounds count as empty too
assign empty = id_beg >= id_end;

//======================================
// Sequential
//======================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		o_rng_valid <= 1'b0;
		o_skip_last <= 1'b0;
	end else begin
		if (pt_acc) begin
			o_rng_valid <= !empty;
		end else if (i_rng_ready) begin
			o_rng_valid <= 1'b0;
		end
		// Dropped final point still has to close the job
		o_skip_last <= pt_acc && empty && i_pt.islast;
	end
end

always_ff @(posedge i_clk) begin
	if (pt_acc && !empty) begin
		o_rng.aofs <= i_pt.aofs;
		o_rng.id_beg <= id_beg;
		o_rng.id_end <= id_end;
		o_rng.islast <= i_pt.islast;
	end
end

endmodule

// ==== warp_issue_stage.sv ====
//======================================
// Warp issue stage
// One record per identifier of a range
//======================================
`include "simd_driver_params.svh"

module warp_issue_stage import simd_driver_pkg::*; (
	input  logic   i_clk,
	input  logic   i_arst_n,
	input  logic   i_start,
	input  logic   i_rng_valid,
	output logic   o_rng_ready,
	input  range_t i_rng,
	input  job_t   i_job,
	output logic   o_inst_valid,
	input  logic   i_inst_ready,
	output inst_t  o_inst,
	output logic   o_last_fire
);

//======================================
// Internal
//======================================
logic [`SD_INST_BW-1:0] pc;
logic [`SD_INST_BW-1:0] pc_cnt;
logic                   pc_live;
logic [`SD_WID_BW-1:0]  warp_cnt;
logic                   inst_fire;
logic                   final_rec;

//======================================
// Combinational
//======================================
// First record of a range starts at id_beg
assign pc = pc_live ? pc_cnt : i_rng.id_beg;
assign final_rec = (pc + 1'b1) == i_rng.id_end;

// Range stays in place upstream until its last record leaves
assign o_inst_valid = i_rng_valid;
assign inst_fire = o_inst_valid && i_inst_ready;
assign o_rng_ready = inst_fire && final_rec;
assign o_last_fire = o_rng_ready && i_rng.islast;

always_comb begin
	o_inst.pc = pc;
	o_inst.warpid = warp_cnt;
	o_inst.aofs = i_rng.aofs;
	// B follows A with the job base, wraps at offset width
	for (int d = 0; d < `SD_VDIM; d++) begin
		o_inst.bofs[d] = i_job.bofs[d] + i_rng.aofs[d];
	end
end

//======================================
// Sequential
//======================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		pc_live <= 1'b0;
		warp_cnt <= '0;
	end else begin
		if (inst_fire) begin
			pc_live <= !final_rec;
		end
		// Warp ids count across the whole job
		if (i_start) begin
			warp_cnt <= '0;
		end else if (inst_fire) begin
			if (warp_cnt == `SD_MAX_WARP - 1) begin
				warp_cnt <= '0;
			end else begin
				warp_cnt <= warp_cnt + 1'b1;
			end
		end
	end
end

always_ff @(posedge i_clk) begin
	if (inst_fire) begin
		pc_cnt <= pc + 1'b1;
	end
end

endmodule

// ==== pending_limiter.sv ====
//======================================
// Pending limiter
// Caps issued but uncommitted records
//======================================
`include "simd_driver_params.svh"

module pending_limiter import simd_driver_pkg::*; (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  logic  i_valid,
	output logic  o_ready,
	input  inst_t i_inst,
	output logic  o_inst_valid,
	input  logic  i_inst_ready,
	output inst_t o_inst,
	input  logic  i_commit,
	output logic  o_idle
);

localparam int CNT_BW = $clog2(`SD_N_PENDING + 1);

//======================================
// Internal
//======================================
logic [CNT_BW-1:0] pend_cnt;
logic              full;
logic              inst_fire;

//======================================
// Combinational
//======================================
assign full = pend_cnt == CNT_BW'(`SD_N_PENDING);

// Both sides of the handshake close at the limit
assign o_inst_valid = i_valid && !full;
assign o_ready = i_inst_ready && !full;
assign o_inst = i_inst;
assign inst_fire = o_inst_valid && i_inst_ready;
assign o_idle = pend_cnt == '0;

//======================================
// Sequential
//======================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		pend_cnt <= '0;
	end else begin
		// Issue and commit together leave the count as is
		case ({inst_fire, i_commit})
			2'b10: pend_cnt <= pend_cnt + 1'b1;
			2'b01: pend_cnt <= pend_cnt - 1'b1;
			default: pend_cnt <= pend_cnt;
		endcase
	end
end

endmodule

// ==== simd_driver_ctrl.sv ====
//======================================
// SIMD driver control
// Job sequencing and acknowledge
//======================================
module simd_driver_ctrl import simd_driver_pkg::*; (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_job_valid,
	output logic o_job_ready,
	output logic o_start,
	input  logic i_skip_last,
	input  logic i_last_fire,
	input  logic i_idle
);

//======================================
// Internal
//======================================
ctrl_state_e state;
ctrl_state_e state_nxt;

//======================================
// Combinational
//======================================
// Start leaves IDLE on the same edge, so it is one cycle wide
assign o_start = (state == IDLE) && i_job_valid;
// Job is held stable until this single-cycle ready
assign o_job_ready = state == ACK;

always_comb begin
	state_nxt = state;
	case (state)
		IDLE: begin
			if (i_job_valid) begin
				state_nxt = WALK;
			end
		end
		// Last item is either an issued record or a dropped point
		WALK: begin
			if (i_last_fire || i_skip_last) begin
				state_nxt = DRAIN;
			end
		end
		// Every record must be committed first
		DRAIN: begin
			if (i_idle) begin
				state_nxt = ACK;
			end
		end
		ACK: begin
			state_nxt = IDLE;
		end
		default: begin
			state_nxt = IDLE;
		end
	endcase
end

//======================================
// Sequential
//======================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		state <= IDLE;
	end else begin
		state <= state_nxt;
	end
end

endmodule

// ==== simd_driver.sv ====
//======================================
// SIMD driver top
// Job in, flow-limited instruction stream out
//======================================
module simd_driver import simd_driver_pkg::*; (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  logic  i_job_valid,
	output logic  o_job_ready,
	input  job_t  i_job,
	output logic  o_inst_valid,
	input  logic  i_inst_ready,
	output inst_t o_inst,
	input  logic  i_commit
);

//======================================
// Internal
//======================================
logic   start;
logic   pt_valid;
logic   pt_ready;
point_t pt;
logic   rng_valid;
logic   rng_ready;
range_t rng;
logic   iss_valid;
logic   iss_ready;
inst_t  iss_inst;
logic   skip_last;
logic   last_fire;
logic   idle;

//======================================
// Submodule
//======================================
simd_driver_ctrl u_ctrl (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_job_valid(i_job_valid),
	.o_job_ready(o_job_ready),
	.o_start(start),
	.i_skip_last(skip_last),
	.i_last_fire(last_fire),
	.i_idle(idle)
);

// Point walk over the A range
offset_stepper u_step (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_start(start),
	.i_job(i_job),
	.o_pt_valid(pt_valid),
	.i_pt_ready(pt_ready),
	.o_pt(pt)
);

inst_range_select u_sel (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_pt_valid(pt_valid),
	.o_pt_ready(pt_ready),
	.i_pt(pt),
	.i_job(i_job),
	.o_rng_valid(rng_valid),
	.i_rng_ready(rng_ready),
	.o_rng(rng),
	.o_skip_last(skip_last)
);

warp_issue_stage u_issue (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_start(start),
	.i_rng_valid(rng_valid),
	.o_rng_ready(rng_ready),
	.i_rng(rng),
	.i_job(i_job),
	.o_inst_valid(iss_valid),
	.i_inst_ready(iss_ready),
	.o_inst(iss_inst),
	.o_last_fire(last_fire)
);

// Output port sits behind the pending limit
pending_limiter u_flow (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_valid(iss_valid),
	.o_ready(iss_ready),
	.i_inst(iss_inst),
	.o_inst_valid(o_inst_valid),
	.i_inst_ready(i_inst_ready),
	.o_inst(o_inst),
	.i_commit(i_commit),
	.o_idle(idle)
);

endmodule

// ==== tb_simd_driver.sv ====
//======================================
// SIMD driver testbench
// Directed jobs against a reference model
//======================================
`include "simd_driver_params.svh"

module tb_simd_driver import simd_driver_pkg::*; ();

timeunit 1ns;
timeprecision 1ps;

// Longest test worst case times four
localparam int CYCLE_LIMIT = 5000;

//======================================
// DUT signals and bookkeeping
//======================================
logic  i_clk;
logic  i_arst_n;
logic  i_job_valid;
logic  o_job_ready;
job_t  i_job;
logic  o_inst_valid;
logic  i_inst_ready;
inst_t o_inst;
logic  i_commit;

inst_t exp_q[$];
int    commit_due[$];
inst_t mon_exp;
int    cycle = 0;
int    accept_pend = 0;
int    outstanding = 0;
int    rx_count = 0;
int    exp_total = 0;
int    err_count = 0;
int    test_err_start = 0;
int    pass_tests = 0;
int    fail_tests = 0;
bit    ready_rand = 1'b0;
bit    commit_hold = 1'b0;
string cur_test = "none";

simd_driver DUT (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_job_valid(i_job_valid),
	.o_job_ready(o_job_ready),
	.i_job(i_job),
	.o_inst_valid(o_inst_valid),
	.i_inst_ready(i_inst_ready),
	.o_inst(o_inst),
	.i_commit(i_commit)
);

// 20 ns clock
initial begin
	i_clk = 1'b0;
	forever #10 i_clk = ~i_clk;
end

always @(posedge i_clk) begin
	cycle = cycle + 1;
end

initial begin
	wait (cycle >= CYCLE_LIMIT);
	$display("Timeout: run reached %0d cycles without finishing", CYCLE_LIMIT);
	$display("Simulation finished: FAIL");
	$finish;
end

//======================================
// Check tasks
//======================================
function automatic string format_inst(input inst_t rec);
	return $sformatf("pc=%0d warp=%0d aofs=%h bofs=%h",
		rec.pc, rec.warpid, rec.aofs, rec.bofs);
endfunction

task automatic check_inst(input string what, input inst_t exp, input inst_t act);
	if (act !== exp) begin
		err_count++;
		$display("CHECK FAILED %s %s: expected %s actual %s",
			cur_test, what, format_inst(exp), format_inst(act));
	end
endtask

task automatic check_count(input string what, input int exp, input int act);
	if (act != exp) begin
		err_count++;
		$display("CHECK FAILED %s %s: expected %0d actual %0d", cur_test, what, exp, act);
	end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
	if (act !== exp) begin
		err_count++;
		$display("CHECK FAILED %s %s: expected %b actual %b", cur_test, what, exp, act);
	end
endtask

//======================================
// Monitor and commit model
//======================================
// Transfers and commits are taken at the rising edge
always @(posedge i_clk) begin
	if (i_commit) begin
		outstanding--;
	end
	if (o_inst_valid && i_inst_ready) begin
		rx_count++;
		accept_pend++;
		outstanding++;
		if (exp_q.size() == 0) begin
			err_count++;
			$display("ERROR %s: record pc=%0d arrived while none was expected",
				cur_test, o_inst.pc);
		end else begin
			mon_exp = exp_q.pop_front();
			check_inst("record", mon_exp, o_inst);
		end
	end
	if (outstanding > `SD_N_PENDING) begin
		err_count++;
		$display("ERROR %s: %0d records outstanding, above the limit of %0d",
			cur_test, outstanding, `SD_N_PENDING);
	end
end

// At most one commit per cycle and each 1 to 4 cycles after its transfer
task automatic drive_flow();
	int due;
	forever begin
		@(negedge i_clk);
		while (accept_pend > 0) begin
			due = cycle + int'($urandom % 4);
			commit_due.push_back(due);
			accept_pend--;
		end
		if (!commit_hold && commit_due.size() > 0 && commit_due[0] <= cycle) begin
			i_commit = 1'b1;
			void'(commit_due.pop_front());
		end else begin
			i_commit = 1'b0;
		end
		// Back-pressure about one cycle in three
		i_inst_ready = ready_rand ? (($urandom % 3) != 0) : 1'b1;
	end
endtask

//======================================
// Reference model
//======================================
// Row-major walk with dimension 0 innermost
function automatic void build_expected(input job_t job);
	int                 n;
	int                 lb;
	int                 le;
	bit                 run_b;
	bit                 run_e;
	ofs_t               pt;
	logic [`SD_WBW-1:0] last_v;
	inst_t              rec;
	n = 0;
	exp_q.delete();
	for (int i1 = job.aofs_beg[1]; i1 < job.aofs_end[1]; i1++) begin
		for (int i0 = job.aofs_beg[0]; i0 < job.aofs_end[0]; i0++) begin
			pt[1] = i1;
			pt[0] = i0;
			lb = 0;
			le = 0;
			run_b = 1'b1;
			run_e = 1'b1;
			for (int d = 0; d < `SD_VDIM; d++) begin
				last_v = job.aofs_end[d] - 1'b1;
				run_b = run_b && (pt[d] == job.aofs_beg[d]);
				run_e = run_e && (pt[d] == last_v);
				lb += run_b;
				le += run_e;
			end
			// Empty or inverted ranges give no records
			for (int id = job.id_begs[lb]; id < job.id_ends[le]; id++) begin
				rec.pc = id;
				rec.warpid = n % `SD_MAX_WARP;
				rec.aofs = pt;
				for (int d = 0; d < `SD_VDIM; d++) begin
					rec.bofs[d] = job.bofs[d] + pt[d];
				end
				exp_q.push_back(rec);
				n++;
			end
		end
	end
endfunction

//======================================
// Job helpers
//======================================
function automatic job_t make_job(input int a0b, a0e, a1b, a1e, b0, b1);
	job_t job;
	job = '0;
	job.aofs_beg[0] = a0b;
	job.aofs_end[0] = a0e;
	job.aofs_beg[1] = a1b;
	job.aofs_end[1] = a1e;
	job.bofs[0] = b0;
	job.bofs[1] = b1;
	return job;
endfunction

// Identifier tables indexed by level 0, 1, 2
function automatic job_t with_ids(input job_t job, input int g0, g1, g2, e0, e1, e2);
	job.id_begs[0] = g0;
	job.id_begs[1] = g1;
	job.id_begs[2] = g2;
	job.id_ends[0] = e0;
	job.id_ends[1] = e1;
	job.id_ends[2] = e2;
	return job;
endfunction

task automatic start_job(input job_t job);
	build_expected(job);
	exp_total = exp_q.size();
	rx_count = 0;
	@(negedge i_clk);
	i_job = job;
	i_job_valid = 1'b1;
endtask

// Job stays valid through the ready cycle
task automatic wait_job_done();
	do begin
		@(negedge i_clk);
	end while (!o_job_ready);
	// Every record is committed before the acknowledge
	check_count("outstanding at ack", 0, outstanding);
	@(negedge i_clk);
	i_job_valid = 1'b0;
	check_bit("job ready after one cycle", 1'b0, o_job_ready);
	check_count("record count", exp_total, rx_count);
	check_count("records never seen", 0, exp_q.size());
endtask

task automatic run_job(input job_t job);
	start_job(job);
	wait_job_done();
endtask

task automatic begin_test(input string name);
	cur_test = name;
	test_err_start = err_count;
endtask

task automatic end_test();
	if (err_count == test_err_start) begin
		pass_tests++;
		$display("%s: passed", cur_test);
	end else begin
		fail_tests++;
		$display("%s: failed with %0d errors", cur_test, err_count - test_err_start);
	end
endtask

//======================================
// Directed tests
//======================================
task automatic test_reset();
	begin_test("reset");
	repeat (16) begin
		@(negedge i_clk);
		check_bit("job ready in reset", 1'b0, o_job_ready);
		check_bit("inst valid in reset", 1'b0, o_inst_valid);
	end
	i_arst_n = 1'b1;
	// Outputs stay quiet with no job offered yet
	repeat (4) begin
		@(negedge i_clk);
		check_bit("job ready after reset", 1'b0, o_job_ready);
		check_bit("inst valid after reset", 1'b0, o_inst_valid);
	end
	end_test();
endtask

task automatic test_single_point();
	begin_test("single_point");
	run_job(with_ids(make_job(5, 6, 3, 4, 8'h10, 8'h20), 1, 1, 2, 9, 9, 7));
	end_test();
endtask

// Prologue, body and epilogue ranges with bofs wrap in dim 0
task automatic test_row_major();
	begin_test("row_major");
	run_job(with_ids(make_job(0, 3, 1, 3, 8'hfe, 8'h40), 4, 2, 0, 7, 9, 11));
	end_test();
endtask

task automatic test_empty_ranges();
	begin_test("empty_ranges");
	// Only level-1 end points issue and the last point is dropped
	run_job(with_ids(make_job(0, 3, 0, 2, 1, 2), 3, 3, 3, 3, 6, 3));
	// Every range empty or inverted
	run_job(with_ids(make_job(2, 4, 2, 4, 0, 0), 5, 5, 5, 1, 2, 0));
	end_test();
endtask

task automatic test_random_ready();
	begin_test("random_ready");
	ready_rand = 1'b1;
	run_job(with_ids(make_job(1, 5, 0, 3, 8'h80, 8'hc0), 0, 1, 2, 3, 4, 5));
	ready_rand = 1'b0;
	end_test();
endtask

task automatic test_commit_hold();
	begin_test("commit_hold");
	commit_hold = 1'b1;
	start_job(with_ids(make_job(0, 2, 0, 2, 3, 4), 0, 0, 0, 4, 4, 4));
	while (outstanding < `SD_N_PENDING) begin
		@(negedge i_clk);
	end
	// Limiter stays closed and the job open while nothing commits
	repeat (20) begin
		@(negedge i_clk);
		check_bit("job ready while held", 1'b0, o_job_ready);
		check_bit("inst valid at limit", 1'b0, o_inst_valid);
	end
	check_count("outstanding at limit", `SD_N_PENDING, outstanding);
	commit_hold = 1'b0;
	wait_job_done();
	end_test();
endtask

//======================================
// Main sequence
//======================================
initial begin
	void'($urandom(32'ha75d));
	i_arst_n = 1'b0;
	i_job_valid = 1'b0;
	i_job = '0;
	i_inst_ready = 1'b0;
	i_commit = 1'b0;
	fork
		drive_flow();
	join_none
	test_reset();
	test_single_point();
	test_row_major();
	test_empty_ranges();
	test_random_ready();
	test_commit_hold();
	$display("Tests: %0d passed, %0d failed, %0d check errors",
		pass_tests, fail_tests, err_count);
	if (err_count == 0 && fail_tests == 0) begin
		$display("Simulation finished: PASS");
	end else begin
		$display("Simulation finished: FAIL");
	end
	$finish;
end

endmodule

// ==== simd_driver.f ====
+incdir+.
simd_driver_pkg.sv
offset_stepper.sv
inst_range_select.sv
warp_issue_stage.sv
pending_limiter.sv
simd_driver_ctrl.sv
simd_driver.sv
tb_simd_driver.sv
